// File: bench/tb_clock.sv
module tb_clock (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held over three rising edges
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
	end

endmodule

// File: bench/wave_chk.sv
module wave_chk
	import wave_pkg::*;
(
	input logic              clk,
	input logic              arst_n,
	input logic              ram_read,
	input logic              ram_valid,
	input logic [NUM_CH-1:0] req,
	input logic [NUM_CH-1:0] rd_valid,
	input logic [NUM_CH-1:0] dac_sck,
	input logic [NUM_CH-1:0] dac_ss_n
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SS_LOW_CYC = 2 * SS_SETUP + FRAME_WID * 2 * SCK_HALF;

	logic pending;

	// reads issued but not yet answered
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pending <= 1'b0;
		else if (ram_read)
			pending <= 1'b1;
		else if (ram_valid)
			pending <= 1'b0;
	end

	a_one_read: assert property (@(posedge clk) disable iff (!arst_n)
		ram_read |-> !pending)
		else $error("second ram_read before ram_valid");

	// the returned word only goes to a channel still waiting for it
	a_rd_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(rd_valid) && (rd_valid & ~req) == '0)
		else $error("rd_valid not one-hot or given to a channel without a request");

	for (genvar c = 0; c < NUM_CH; c++) begin : g_spi
		int low_cnt;

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n)
				low_cnt <= 0;
			else if (!dac_ss_n[c])
				low_cnt <= low_cnt + 1;
			else
				low_cnt <= 0;
		end

		a_ss_len: assert property (@(posedge clk) disable iff (!arst_n)
			$rose(dac_ss_n[c]) |-> low_cnt == SS_LOW_CYC)
			else $error("chip select low for wrong number of cycles");

		a_sck_idle: assert property (@(posedge clk) disable iff (!arst_n)
			dac_ss_n[c] |-> !dac_sck[c])
			else $error("sck toggles while chip select is high");
	end

endmodule

bind wave_top wave_chk i_chk (.*);

// File: bench/wave_tb.sv
module wave_tb
	import wave_pkg::*, wave_regs_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FETCH_BOUND = NUM_CH * 6;
	localparam int FRAME_CYC = 2 * SS_SETUP + FRAME_WID * 2 * SCK_HALF + 2;
	// samples times (period + fetch + frame) for each test
	localparam int TEST_CYC = 10 * (20 + FETCH_BOUND + FRAME_CYC)
		+ 32 * (52 + FETCH_BOUND + FRAME_CYC) + 3 * (5 + FETCH_BOUND + FRAME_CYC);
	localparam int CYCLE_LIMIT = 2 * TEST_CYC;

	logic clk;
	logic arst_n;
	logic [7:0] s_axi_awaddr, s_axi_araddr;
	logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
	logic [31:0] s_axi_wdata, s_axi_rdata;
	logic [3:0] s_axi_wstrb;
	logic [1:0] s_axi_bresp, s_axi_rresp;
	logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
	logic s_axi_rvalid, s_axi_rready;
	logic [31:0] ram_addr, ram_word;
	logic ram_read, ram_valid;
	logic [NUM_CH-1:0] dac_sck, dac_mosi, dac_ss_n;

	logic [31:0] cfg_start [NUM_CH];
	logic [31:0] cfg_len [NUM_CH];
	logic [31:0] cfg_period [NUM_CH];
	int arm_gen [NUM_CH];
	int frame_cnt [NUM_CH];
	int cycle;

	tb_clock i_clk (.clk(clk), .arst_n(arst_n));

	wave_top i_dut (.*);

	task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic fail_msg(input string what);
		$display("%0t %s", $time, what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] mem_hash(input logic [31:0] addr);
		return (addr * 32'h9E3779B1) ^ {addr[15:0], addr[31:16]};
	endfunction

	// command 0001 then the low 20 bits of the word
	function automatic logic [23:0] ref_frame(input logic [31:0] start, input int idx);
		logic [31:0] w;
		w = mem_hash(start + 32'(idx * 4));
		return {4'b0001, w[19:0]};
	endfunction

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > CYCLE_LIMIT)
			fail_msg("timeout, the run took too many cycles");
	end

	// memory with 1 to 4 cycles of latency
	initial begin : mem_model
		logic [31:0] addr;
		int lat;
		void'($urandom(53915));
		forever begin
			@(posedge clk);
			if (ram_read) begin
				addr = ram_addr;
				lat = $urandom_range(4, 1);
				repeat (lat - 1) @(posedge clk);
				#1;
				ram_word = mem_hash(addr);
				ram_valid = 1'b1;
				@(posedge clk);
				#1 ram_valid = 1'b0;
			end
		end
	end

	for (genvar c = 0; c < NUM_CH; c++) begin : g_mon
		logic [23:0] frames [$];
		logic [23:0] shift;
		int nbits = 0;
		int count = 0;
		int idx = 0;
		int seen_gen = 0;
		logic prev_ss = 1'b1;
		logic seen_rise = 1'b0;
		int rise_cyc = 0;

		assign frame_cnt[c] = count;

		always @(negedge dac_sck[c]) begin
			if (!dac_ss_n[c]) begin
				shift = {shift[22:0], dac_mosi[c]};
				nbits = nbits + 1;
				if (nbits == FRAME_WID) begin
					frames.push_back(shift);
					nbits = 0;
				end
			end
		end

		always @(posedge clk) begin : compare
			logic [23:0] f;
			logic [23:0] exp;
			if (arm_gen[c] != seen_gen) begin
				seen_gen = arm_gen[c];
				idx = 0;
			end
			while (frames.size() > 0) begin
				f = frames.pop_front();
				exp = ref_frame(cfg_start[c], idx);
				assert (f == exp)
					else fail_value($sformatf("dac_mosi[%0d] frame", c), 32'(exp), 32'(f));
				idx = (idx + 1) % (cfg_len[c] == 0 ? 1 : int'(cfg_len[c]));
				count = count + 1;
			end
		end

		// idle gap between frames
		always @(posedge clk) begin
			if (!prev_ss && dac_ss_n[c]) begin
				rise_cyc = cycle;
				seen_rise = 1'b1;
			end
			if (prev_ss && !dac_ss_n[c] && seen_rise)
				assert (cycle - rise_cyc >= int'(cfg_period[c]) + 1)
					else fail_msg($sformatf("channel %0d started a frame too early", c));
			prev_ss = dac_ss_n[c];
		end
	end

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		s_axi_awaddr = addr;
		s_axi_wdata = data;
		s_axi_wstrb = strb;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		@(posedge clk);
		while (!s_axi_awready)
			@(posedge clk);
		#1;
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b1;
		@(posedge clk);
		while (!s_axi_bvalid)
			@(posedge clk);
		resp = s_axi_bresp;
		#1 s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		@(posedge clk);
		while (!s_axi_arready)
			@(posedge clk);
		#1;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b1;
		@(posedge clk);
		while (!s_axi_rvalid)
			@(posedge clk);
		data = s_axi_rdata;
		resp = s_axi_rresp;
		#1 s_axi_rready = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, 4'hF, resp);
		assert (resp == 2'b00) else fail_value("s_axi_bresp", 32'h0, 32'(resp));
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] exp,
			input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(addr, data, resp);
		assert (resp == exp_resp) else fail_value("s_axi_rresp", 32'(exp_resp), 32'(resp));
		assert (data == exp)
			else fail_value($sformatf("s_axi_rdata @%h", addr), exp, data);
	endtask

	task automatic setup_channel(input int c, input logic [31:0] start,
			input logic [31:0] len, input logic [31:0] per);
		cfg_start[c] = start;
		cfg_len[c] = len;
		cfg_period[c] = per;
		write_reg(8'(c * 16 + 4), start);
		write_reg(8'(c * 16 + 8), len);
		write_reg(8'(c * 16 + 12), per);
	endtask

	task automatic set_arm(input int c, input logic on);
		if (on)
			arm_gen[c] = arm_gen[c] + 1;
		write_reg(8'(c * 16), {31'b0, on});
	endtask

	task automatic wait_frames(input int c, input int n);
		while (frame_cnt[c] < n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// polls the busy bits of the status register
	task automatic wait_idle(input logic [3:0] mask);
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(8'h40, data, resp);
		while ((data[3:0] & mask) != 0)
			axi_read(8'h40, data, resp);
	endtask

	initial begin : main
		logic [1:0] resp;
		int at_disarm;
		int base_cnt [NUM_CH];
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		ram_word = '0;
		ram_valid = 1'b0;
		cycle = 0;
		for (int c = 0; c < NUM_CH; c++) begin
			cfg_start[c] = '0;
			cfg_len[c] = 32'd1;
			cfg_period[c] = '0;
			arm_gen[c] = 0;
		end
		wait (arst_n);
		@(posedge clk);
		#1;

		// register readback and error responses
		setup_channel(1, 32'h100, 32'd7, 32'd33);
		check_read(8'h14, 32'h100, 2'b00);
		check_read(8'h18, 32'd7, 2'b00);
		check_read(8'h1C, 32'd33, 2'b00);
		axi_write(8'h1C, 32'hAABBCCDD, 4'b0001, resp);
		check_read(8'h1C, 32'hDD, 2'b00);
		cfg_period[1] = 32'hDD;
		axi_write(8'h50, 32'h1234, 4'hF, resp);
		assert (resp == 2'b10) else fail_value("s_axi_bresp", 32'h2, 32'(resp));
		check_read(8'h50, 32'h0, 2'b10);
		check_read(8'h02, 32'h0, 2'b10);

		// one channel, two sweeps, then disarm
		setup_channel(0, 32'h1000, 32'd5, 32'd20);
		set_arm(0, 1'b1);
		wait_frames(0, 10);
		at_disarm = frame_cnt[0];
		set_arm(0, 1'b0);
		wait_idle(4'b0001);
		repeat (FRAME_CYC) @(posedge clk);
		#1;
		assert (frame_cnt[0] <= at_disarm + 1)
			else fail_msg("more than one frame after disarm");
		check_read(8'h40, 32'h100, 2'b00);
		write_reg(8'h40, 32'h100);
		check_read(8'h40, 32'h0, 2'b00);

		// count of 0 acts as 1
		setup_channel(2, 32'h2000, 32'd0, 32'd5);
		set_arm(2, 1'b1);
		wait_frames(2, 3);
		set_arm(2, 1'b0);
		wait_idle(4'b0100);
		check_read(8'h40, 32'h400, 2'b00);
		write_reg(8'h40, 32'h400);

		// all channels together
		for (int c = 0; c < NUM_CH; c++)
			setup_channel(c, 32'h4000 + 32'(c * 32'h400), 32'd4, 32'(30 + c * 7));
		for (int c = 0; c < NUM_CH; c++)
			base_cnt[c] = frame_cnt[c];
		for (int c = 0; c < NUM_CH; c++)
			set_arm(c, 1'b1);
		for (int c = 0; c < NUM_CH; c++)
			wait_frames(c, base_cnt[c] + 8);
		for (int c = 0; c < NUM_CH; c++)
			set_arm(c, 1'b0);
		wait_idle(4'b1111);
		check_read(8'h40, 32'hF00, 2'b00);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: run.sh
#!/bin/sh
# builds and runs the waveform player testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv --top-module wave_tb -f src.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vwave_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// File: src.f
src/wave_pkg.sv
src/wave_regs_pkg.sv
src/dac_spi_tx.sv
src/wave_channel.sv
src/ram_arbiter.sv
src/wave_regs.sv
src/wave_top.sv
bench/tb_clock.sv
bench/wave_chk.sv
bench/wave_tb.sv

// File: src/dac_spi_tx.sv
module dac_spi_tx
	import wave_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 start,
	input  logic [FRAME_WID-1:0] frame,
	output logic                 done,
	output logic                 sck,
	output logic                 mosi,
	output logic                 ss_n
);
	localparam int BIT_CYC = 2 * SCK_HALF;
	localparam int SHIFT_CYC = FRAME_WID * BIT_CYC;
	localparam int TOTAL_CYC = SS_SETUP + SHIFT_CYC + SS_SETUP;
	localparam int CNT_WID = $clog2(TOTAL_CYC);

	logic active;
	logic [CNT_WID-1:0] cnt;
	logic [CNT_WID-1:0] cnt_nxt;
	logic [CNT_WID-1:0] pos;
	logic in_shift;
	logic sck_nxt;
	logic rise_nxt;
	logic [FRAME_WID-1:0] shreg;

	// cnt is the index of the current cycle with ss_n low
	assign cnt_nxt = cnt + 1'b1;
	assign pos = cnt_nxt - CNT_WID'(SS_SETUP);
	assign in_shift = cnt_nxt >= CNT_WID'(SS_SETUP) && cnt_nxt < CNT_WID'(SS_SETUP + SHIFT_CYC);
	// high half first, data moves on the rising edge
	assign sck_nxt = in_shift && ((int'(pos) % BIT_CYC) < SCK_HALF);
	assign rise_nxt = in_shift && ((int'(pos) % BIT_CYC) == 0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
			sck <= 1'b0;
			mosi <= 1'b0;
			ss_n <= 1'b1;
		end else begin
			done <= 1'b0;
			if (!active) begin
				if (start) begin
					active <= 1'b1;
					cnt <= '0;
					ss_n <= 1'b0;
				end
			end else if (cnt == CNT_WID'(TOTAL_CYC - 1)) begin
				active <= 1'b0;
				done <= 1'b1;
				ss_n <= 1'b1;
				sck <= 1'b0;
				mosi <= 1'b0;
			end else begin
				cnt <= cnt_nxt;
				sck <= sck_nxt;
				if (rise_nxt)
					mosi <= shreg[FRAME_WID-1];
			end
		end
	end

	// msb first
	always_ff @(posedge clk) begin
		if (!active && start)
			shreg <= frame;
		else if (active && rise_nxt)
			shreg <= shreg << 1;
	end

endmodule

// File: src/ram_arbiter.sv
module ram_arbiter
	import wave_pkg::*;
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [NUM_CH-1:0]          req,
	input  logic [NUM_CH*ADDR_WID-1:0] req_addr,
	output logic [NUM_CH-1:0]          rd_valid,
	output logic [ADDR_WID-1:0]        ram_addr,
	output logic                       ram_read,
	input  logic                       ram_valid
);
	localparam int SEL_WID = $clog2(NUM_CH);

	logic busy;
	logic found;
	logic [SEL_WID-1:0] ptr;
	logic [SEL_WID-1:0] owner;
	logic [SEL_WID-1:0] winner;

	// first requester at or after the pointer
	always_comb begin : pick
		logic [SEL_WID-1:0] cand;
		found = 1'b0;
		winner = ptr;
		for (int i = 0; i < NUM_CH; i++) begin
			cand = SEL_WID'((int'(ptr) + i) % NUM_CH);
			if (!found && req[cand]) begin
				found = 1'b1;
				winner = cand;
			end
		end
	end

	assign rd_valid = (busy && ram_valid) ? NUM_CH'(1) << owner : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			ptr <= '0;
			owner <= '0;
			ram_read <= 1'b0;
		end else begin
			ram_read <= 1'b0;
			if (!busy) begin
				if (found) begin
					busy <= 1'b1;
					owner <= winner;
					ram_read <= 1'b1;
				end
			end else if (ram_valid) begin
				busy <= 1'b0;
				ptr <= (owner == SEL_WID'(NUM_CH - 1)) ? '0 : owner + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && found)
			ram_addr <= req_addr[winner*ADDR_WID +: ADDR_WID];
	end

endmodule

// File: src/wave_channel.sv
module wave_channel
	import wave_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    arm,
	input  logic [ADDR_WID-1:0]     start_addr,
	input  logic [LEN_WID-1:0]      sample_len,
	input  logic [TIMER_WID-1:0]    period,
	output logic                    req,
	output logic [ADDR_WID-1:0]     req_addr,
	input  logic                    rd_valid,
	input  logic [RAM_WORD_WID-1:0] ram_word,
	output logic                    busy,
	output logic                    sweep_done,
	output logic                    dac_sck,
	output logic                    dac_mosi,
	output logic                    dac_ss_n
);
	chan_state_e state;
	logic [TIMER_WID-1:0] timer;
	logic [LEN_WID-1:0] idx;
	logic [LEN_WID:0] idx_inc;
	logic last_sample;
	logic [FRAME_WID-1:0] frame;
	logic tx_start;
	logic tx_done;

	assign idx_inc = {1'b0, idx} + 1'b1;
	// a count of 0 ends the sweep after one sample
	assign last_sample = idx_inc >= {1'b0, sample_len};
	assign busy = state != IDLE;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			timer <= '0;
			idx <= '0;
			req <= 1'b0;
			req_addr <= '0;
			tx_start <= 1'b0;
			sweep_done <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			sweep_done <= 1'b0;
			case (state)
				IDLE: begin
					if (arm) begin
						state <= WAIT_PERIOD;
						timer <= period;
						idx <= '0;
						req_addr <= start_addr;
					end
				end
				WAIT_PERIOD: begin
					if (!arm) begin
						state <= IDLE;
					end else if (timer == '0) begin
						state <= FETCH;
						req <= 1'b1;
					end else begin
						timer <= timer - 1'b1;
					end
				end
				// request stays up until the word comes back
				FETCH: begin
					if (rd_valid) begin
						state <= SEND;
						req <= 1'b0;
						tx_start <= 1'b1;
					end
				end
				SEND: begin
					if (tx_done) begin
						if (last_sample) begin
							sweep_done <= 1'b1;
							idx <= '0;
							req_addr <= start_addr;
						end else begin
							idx <= idx_inc[LEN_WID-1:0];
							req_addr <= req_addr + ADDR_WID'(SAMPLE_BYTES);
						end
						if (arm) begin
							state <= WAIT_PERIOD;
							timer <= period;
						end else begin
							state <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH && rd_valid)
			frame <= {WRITE_UPDATE, ram_word[SAMPLE_WID-1:0]};
	end

	dac_spi_tx i_spi (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (tx_start),
		.frame  (frame),
		.done   (tx_done),
		.sck    (dac_sck),
		.mosi   (dac_mosi),
		.ss_n   (dac_ss_n)
	);

endmodule

// File: src/wave_pkg.sv
package wave_pkg;

	localparam int NUM_CH = 4;
	localparam int ADDR_WID = 32;
	localparam int RAM_WORD_WID = 32;

	// DAC data bits, taken from the low end of a memory word
	localparam int SAMPLE_WID = 20;
	localparam int FRAME_WID = 24;
	localparam int CMD_WID = FRAME_WID - SAMPLE_WID;
	localparam int LEN_WID = 16;
	localparam int TIMER_WID = 32;

	// byte step between consecutive samples
	localparam int SAMPLE_BYTES = 4;

	// SPI timing in system clock cycles
	localparam int SCK_HALF = 2;
	localparam int SS_SETUP = 3;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_PERIOD,
		FETCH,
		SEND
	} chan_state_e;

	// NOP is reserved by the DAC
	typedef enum logic [CMD_WID-1:0] {
		NOP = 4'b0000,
		WRITE_UPDATE = 4'b0001
	} dac_cmd_e;

endpackage

// File: src/wave_regs.sv
module wave_regs
	import wave_pkg::*, wave_regs_pkg::*;
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [AXI_ADDR_WID-1:0]     s_axi_awaddr,
	input  logic                        s_axi_awvalid,
	output logic                        s_axi_awready,
	input  logic [AXI_DATA_WID-1:0]     s_axi_wdata,
	input  logic [AXI_DATA_WID/8-1:0]   s_axi_wstrb,
	input  logic                        s_axi_wvalid,
	output logic                        s_axi_wready,
	output logic [1:0]                  s_axi_bresp,
	output logic                        s_axi_bvalid,
	input  logic                        s_axi_bready,
	input  logic [AXI_ADDR_WID-1:0]     s_axi_araddr,
	input  logic                        s_axi_arvalid,
	output logic                        s_axi_arready,
	output logic [AXI_DATA_WID-1:0]     s_axi_rdata,
	output logic [1:0]                  s_axi_rresp,
	output logic                        s_axi_rvalid,
	input  logic                        s_axi_rready,
	output logic [NUM_CH-1:0]           arm,
	output logic [NUM_CH*ADDR_WID-1:0]  start_addr,
	output logic [NUM_CH*LEN_WID-1:0]   sample_len,
	output logic [NUM_CH*TIMER_WID-1:0] period,
	input  logic [NUM_CH-1:0]           busy,
	input  logic [NUM_CH-1:0]           sweep_done
);
	localparam int OFF_WID = $clog2(CH_STRIDE);
	localparam int SEL_WID = $clog2(NUM_CH);

	axi_state_e state;
	logic wr_go;
	logic rd_go;
	logic wr_cfg;
	logic [SEL_WID-1:0] wr_ch;
	logic [OFF_WID-1:0] wr_off;
	logic [AXI_DATA_WID-1:0] wr_merged;
	logic [NUM_CH-1:0] done_flag;
	logic [NUM_CH-1:0] done_clr;

	function automatic logic addr_hit(input logic [AXI_ADDR_WID-1:0] addr);
		logic [OFF_WID-1:0] off;
		off = addr[OFF_WID-1:0];
		if (addr == REG_STATUS)
			return 1'b1;
		if (int'(addr) >= NUM_CH * CH_STRIDE)
			return 1'b0;
		return off == REG_CTRL || off == REG_START || off == REG_LEN || off == REG_PERIOD;
	endfunction

	// current contents of a register, 0 when unmapped
	function automatic logic [AXI_DATA_WID-1:0] reg_value(input logic [AXI_ADDR_WID-1:0] addr);
		logic [SEL_WID-1:0] ch;
		logic [AXI_DATA_WID-1:0] val;
		ch = addr[OFF_WID +: SEL_WID];
		val = '0;
		if (addr == REG_STATUS) begin
			val[NUM_CH-1:0] = busy;
			val[STAT_DONE_LSB +: NUM_CH] = done_flag;
		end else if (addr_hit(addr)) begin
			case (addr[OFF_WID-1:0])
				REG_CTRL: val[0] = arm[ch];
				REG_START: val = AXI_DATA_WID'(start_addr[ch*ADDR_WID +: ADDR_WID]);
				REG_LEN: val = AXI_DATA_WID'(sample_len[ch*LEN_WID +: LEN_WID]);
				default: val = AXI_DATA_WID'(period[ch*TIMER_WID +: TIMER_WID]);
			endcase
		end
		return val;
	endfunction

	assign wr_go = state == AXI_IDLE && s_axi_awvalid && s_axi_wvalid;
	// a write in the same cycle wins
	assign rd_go = state == AXI_IDLE && s_axi_arvalid && !wr_go;
	assign s_axi_awready = wr_go;
	assign s_axi_wready = wr_go;
	assign s_axi_arready = rd_go;
	assign wr_ch = s_axi_awaddr[OFF_WID +: SEL_WID];
	assign wr_off = s_axi_awaddr[OFF_WID-1:0];

	always_comb begin
		wr_merged = reg_value(s_axi_awaddr);
		for (int b = 0; b < AXI_DATA_WID / 8; b++) begin
			if (s_axi_wstrb[b])
				wr_merged[8*b +: 8] = s_axi_wdata[8*b +: 8];
		end
		wr_cfg = wr_go && addr_hit(s_axi_awaddr) && s_axi_awaddr != REG_STATUS;
		done_clr = '0;
		if (wr_go && s_axi_awaddr == REG_STATUS && s_axi_wstrb[STAT_DONE_LSB / 8])
			done_clr = s_axi_wdata[STAT_DONE_LSB +: NUM_CH];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= AXI_IDLE;
			s_axi_bvalid <= 1'b0;
			s_axi_rvalid <= 1'b0;
		end else begin
			case (state)
				AXI_IDLE: begin
					if (wr_go) begin
						state <= AXI_WRESP;
						s_axi_bvalid <= 1'b1;
					end else if (rd_go) begin
						state <= AXI_RDATA;
						s_axi_rvalid <= 1'b1;
					end
				end
				AXI_WRESP: begin
					if (s_axi_bready) begin
						state <= AXI_IDLE;
						s_axi_bvalid <= 1'b0;
					end
				end
				AXI_RDATA: begin
					if (s_axi_rready) begin
						state <= AXI_IDLE;
						s_axi_rvalid <= 1'b0;
					end
				end
				default: state <= AXI_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go)
			s_axi_bresp <= addr_hit(s_axi_awaddr) ? RESP_OKAY : RESP_SLVERR;
		if (rd_go) begin
			s_axi_rdata <= reg_value(s_axi_araddr);
			s_axi_rresp <= addr_hit(s_axi_araddr) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arm <= '0;
			start_addr <= '0;
			sample_len <= '0;
			period <= '0;
			done_flag <= '0;
		end else begin
			// new pulse beats a clear
			done_flag <= (done_flag & ~done_clr) | sweep_done;
			if (wr_cfg) begin
				case (wr_off)
					REG_CTRL: arm[wr_ch] <= wr_merged[0];
					REG_START: start_addr[wr_ch*ADDR_WID +: ADDR_WID] <= wr_merged[ADDR_WID-1:0];
					REG_LEN: sample_len[wr_ch*LEN_WID +: LEN_WID] <= wr_merged[LEN_WID-1:0];
					default: period[wr_ch*TIMER_WID +: TIMER_WID] <= wr_merged[TIMER_WID-1:0];
				endcase
			end
		end
	end

endmodule

// File: src/wave_regs_pkg.sv
package wave_regs_pkg;

	localparam int AXI_ADDR_WID = 8;
	localparam int AXI_DATA_WID = 32;

	// one block of registers per channel
	localparam int CH_STRIDE = 16;
	localparam logic [3:0] REG_CTRL = 4'h0;
	localparam logic [3:0] REG_START = 4'h4;
	localparam logic [3:0] REG_LEN = 4'h8;
	localparam logic [3:0] REG_PERIOD = 4'hC;

	// busy in the low bits, sticky sweep-done from bit 8
	localparam logic [AXI_ADDR_WID-1:0] REG_STATUS = 8'h40;
	localparam int STAT_DONE_LSB = 8;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic [1:0] {
		AXI_IDLE,
		AXI_WRESP,
		AXI_RDATA
	} axi_state_e;

endpackage

// File: src/wave_top.sv
module wave_top
	import wave_pkg::*, wave_regs_pkg::*;
(
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [AXI_ADDR_WID-1:0]   s_axi_awaddr,
	input  logic                      s_axi_awvalid,
	output logic                      s_axi_awready,
	input  logic [AXI_DATA_WID-1:0]   s_axi_wdata,
	input  logic [AXI_DATA_WID/8-1:0] s_axi_wstrb,
	input  logic                      s_axi_wvalid,
	output logic                      s_axi_wready,
	output logic [1:0]                s_axi_bresp,
	output logic                      s_axi_bvalid,
	input  logic                      s_axi_bready,
	input  logic [AXI_ADDR_WID-1:0]   s_axi_araddr,
	input  logic                      s_axi_arvalid,
	output logic                      s_axi_arready,
	output logic [AXI_DATA_WID-1:0]   s_axi_rdata,
	output logic [1:0]                s_axi_rresp,
	output logic                      s_axi_rvalid,
	input  logic                      s_axi_rready,
	output logic [ADDR_WID-1:0]       ram_addr,
	output logic                      ram_read,
	input  logic [RAM_WORD_WID-1:0]   ram_word,
	input  logic                      ram_valid,
	output logic [NUM_CH-1:0]         dac_sck,
	output logic [NUM_CH-1:0]         dac_mosi,
	output logic [NUM_CH-1:0]         dac_ss_n
);
	logic [NUM_CH-1:0] arm;
	logic [NUM_CH*ADDR_WID-1:0] start_addr;
	logic [NUM_CH*LEN_WID-1:0] sample_len;
	logic [NUM_CH*TIMER_WID-1:0] period;
	logic [NUM_CH-1:0] busy;
	logic [NUM_CH-1:0] sweep_done;
	logic [NUM_CH-1:0] req;
	logic [NUM_CH*ADDR_WID-1:0] req_addr;
	logic [NUM_CH-1:0] rd_valid;

	wave_regs i_regs (.*);

	for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
		wave_channel i_chan (
			.clk        (clk),
			.arst_n     (arst_n),
			.arm        (arm[c]),
			.start_addr (start_addr[c*ADDR_WID +: ADDR_WID]),
			.sample_len (sample_len[c*LEN_WID +: LEN_WID]),
			.period     (period[c*TIMER_WID +: TIMER_WID]),
			.req        (req[c]),
			.req_addr   (req_addr[c*ADDR_WID +: ADDR_WID]),
			.rd_valid   (rd_valid[c]),
			.ram_word   (ram_word),
			.busy       (busy[c]),
			.sweep_done (sweep_done[c]),
			.dac_sck    (dac_sck[c]),
			.dac_mosi   (dac_mosi[c]),
			.dac_ss_n   (dac_ss_n[c])
		);
	end

	// one read in flight, word goes straight to every channel
	ram_arbiter i_arb (.*);

endmodule
